//--- fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ==========================================================================
// fetch buffer sizing
// ==========================================================================

// number of buffered cache lines
`define FB_ENTRIES   4

// width of an entry index
`define FB_IDX_BITS  2

// one icache line
`define FB_LINE_BITS 128

// pc bits 31 to 4
`define FB_TAG_BITS  28

`endif

//--- fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  // refill FSM states
  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_ADDR = 2'd1,
    S_DATA = 2'd2
  } fetch_state_e;

  // read channel response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_EXOKAY = 2'd1,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } rresp_e;

  // write strobe into one entry, shared by all entries
  typedef struct packed {
    logic                     we;
    logic [`FB_IDX_BITS-1:0]  idx;
    logic [`FB_TAG_BITS-1:0]  tag;
    logic [`FB_LINE_BITS-1:0] data;
  } fill_t;

  // answer of one entry to the current pc
  typedef struct packed {
    logic                     hit;
    logic [`FB_LINE_BITS-1:0] data;
  } lookup_t;

  // line forwarded in its return cycle
  typedef struct packed {
    logic                     valid;
    logic [`FB_LINE_BITS-1:0] data;
  } bypass_t;

endpackage

`default_nettype wire

//--- fetch_line_entry.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_line_entry #(
  parameter int unsigned ENTRY_IDX = 0
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire fetch_pkg::fill_t    fill_i,
  input  wire [`FB_TAG_BITS-1:0]   tag_i,
  output fetch_pkg::lookup_t       lookup_o
);

  localparam logic [`FB_IDX_BITS-1:0] MY_IDX = ENTRY_IDX[`FB_IDX_BITS-1:0];

  logic                     valid_q;
  logic [`FB_TAG_BITS-1:0]  tag_q;
  logic [`FB_LINE_BITS-1:0] data_q;
  logic                     wr_en;

  // only the entry picked by the victim pointer takes the fill
  assign wr_en = fill_i.we && (fill_i.idx == MY_IDX);

  always_ff @(posedge clk) begin
    if (rst_n) begin
      valid_q <= 1'b0;
    end else if (wr_en) begin
      valid_q <= 1'b1;
    end
  end

  // line payload
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_q  <= fill_i.tag;
      data_q <= fill_i.data;
    end
  end

  // tag compare against the current pc
  assign lookup_o.hit  = valid_q && (tag_q == tag_i);
  assign lookup_o.data = data_q;

endmodule

`default_nettype wire

//--- fetch_refill_ctrl.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_refill_ctrl (
  input  wire                                     clk,
  input  wire                                     rst_n,
  input  wire [31:0]                              pc_i,
  input  wire                                     jmp_flush_i,
  input  wire fetch_pkg::lookup_t [`FB_ENTRIES-1:0] lookups_i,
  input  wire                                     ar_ready_i,
  output logic                                    ar_valid_o,
  output logic [31:0]                             ar_addr_o,
  input  wire                                     r_valid_i,
  input  wire [`FB_LINE_BITS-1:0]                 r_data_i,
  input  wire fetch_pkg::rresp_e                  r_resp_i,
  output logic                                    r_ready_o,
  output fetch_pkg::fill_t                        fill_o,
  output fetch_pkg::bypass_t                      bypass_o
);

  fetch_pkg::fetch_state_e  state_q;
  fetch_pkg::fetch_state_e  state_d;
  logic [`FB_TAG_BITS-1:0]  line_q;
  logic                     stale_q;
  logic [`FB_IDX_BITS-1:0]  victim_q;
  logic                     any_hit;
  logic                     r_xfer;
  logic                     resp_ok;
  logic                     keep;

  // ==========================================================================
  // miss detection
  // ==========================================================================

  always_comb begin
    any_hit = 1'b0;
    for (int i = 0; i < `FB_ENTRIES; i++) begin
      any_hit = any_hit | lookups_i[i].hit;
    end
  end

  assign r_xfer  = r_valid_i && r_ready_o;
  assign resp_ok = (r_resp_i == fetch_pkg::RESP_OKAY) ||
                   (r_resp_i == fetch_pkg::RESP_EXOKAY);

  // returning line survives only if still wanted and not flushed away
  assign keep = r_xfer && resp_ok && (line_q == pc_i[31:4]) &&
                !stale_q && !jmp_flush_i;

  // ==========================================================================
  // read channel FSM
  // ==========================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      fetch_pkg::S_IDLE: begin
        if (!any_hit) begin
          state_d = fetch_pkg::S_ADDR;
        end
      end
      fetch_pkg::S_ADDR: begin
        if (ar_ready_i) begin
          state_d = fetch_pkg::S_DATA;
        end
      end
      fetch_pkg::S_DATA: begin
        if (r_valid_i) begin
          state_d = fetch_pkg::S_IDLE;
        end
      end
      default: begin
        state_d = fetch_pkg::S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q  <= fetch_pkg::S_IDLE;
      stale_q  <= 1'b0;
      victim_q <= '0;
    end else begin
      state_q <= state_d;
      // a jump while the line is in flight makes it useless
      if (state_q == fetch_pkg::S_IDLE) begin
        stale_q <= 1'b0;
      end else if (jmp_flush_i) begin
        stale_q <= 1'b1;
      end
      // round robin victim advances only on a kept fill
      if (keep) begin
        victim_q <= victim_q + 1'b1;
      end
    end
  end

  // miss line address held for the whole refill
  always_ff @(posedge clk) begin
    if (state_q == fetch_pkg::S_IDLE && !any_hit) begin
      line_q <= pc_i[31:4];
    end
  end

  assign ar_valid_o = (state_q == fetch_pkg::S_ADDR);
  assign ar_addr_o  = {line_q, 4'b0000};
  assign r_ready_o  = (state_q == fetch_pkg::S_DATA);

  // fill goes to the victim and the same data is forwarded this cycle
  assign fill_o.we     = keep;
  assign fill_o.idx    = victim_q;
  assign fill_o.tag    = line_q;
  assign fill_o.data   = r_data_i;
  assign bypass_o.valid = keep;
  assign bypass_o.data  = r_data_i;

endmodule

`default_nettype wire

//--- fetch_inst_select.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_inst_select (
  input  wire [31:0]                                pc_i,
  input  wire fetch_pkg::lookup_t [`FB_ENTRIES-1:0] lookups_i,
  input  wire fetch_pkg::bypass_t                   bypass_i,
  output logic                                      inst_valid_o,
  output logic [31:0]                               inst_o
);

  logic                     any_hit;
  logic [`FB_LINE_BITS-1:0] line;
  logic [31:0]              word;

  // ==========================================================================
  // line merge
  // ==========================================================================

  // at most one entry hits, so an and-or mux is enough
  always_comb begin
    any_hit = 1'b0;
    line    = '0;
    for (int i = 0; i < `FB_ENTRIES; i++) begin
      any_hit = any_hit | lookups_i[i].hit;
      line    = line | ({`FB_LINE_BITS{lookups_i[i].hit}} & lookups_i[i].data);
    end
    // refill data only shows up on a miss
    if (bypass_i.valid) begin
      line = bypass_i.data;
    end
  end

  // word select by pc[3:2]
  always_comb begin
    case (pc_i[3:2])
      2'd0:    word = line[31:0];
      2'd1:    word = line[63:32];
      2'd2:    word = line[95:64];
      default: word = line[127:96];
    endcase
  end

  assign inst_valid_o = any_hit || bypass_i.valid;
  assign inst_o       = inst_valid_o ? word : 32'h0;

endmodule

`default_nettype wire

//--- fetch_buffer_top.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_buffer_top (
  input  wire                       clk,
  input  wire                       rst_n,
  // fetch unit side
  input  wire [31:0]                pc_i,
  input  wire                       jmp_flush_i,
  output logic                      inst_valid_o,
  output logic [31:0]               inst_o,
  // icache read channel
  output logic                      ar_valid_o,
  output logic [31:0]               ar_addr_o,
  input  wire                       ar_ready_i,
  input  wire                       r_valid_i,
  input  wire [`FB_LINE_BITS-1:0]   r_data_i,
  input  wire [1:0]                 r_resp_i,
  output logic                      r_ready_o
);

  fetch_pkg::fill_t                     fill;
  fetch_pkg::bypass_t                   bypass;
  fetch_pkg::lookup_t [`FB_ENTRIES-1:0] lookups;

  fetch_refill_ctrl u_fetch_refill_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc_i        (pc_i),
    .jmp_flush_i (jmp_flush_i),
    .lookups_i   (lookups),
    .ar_ready_i  (ar_ready_i),
    .ar_valid_o  (ar_valid_o),
    .ar_addr_o   (ar_addr_o),
    .r_valid_i   (r_valid_i),
    .r_data_i    (r_data_i),
    .r_resp_i    (fetch_pkg::rresp_e'(r_resp_i)),
    .r_ready_o   (r_ready_o),
    .fill_o      (fill),
    .bypass_o    (bypass)
  );

  // ==========================================================================
  // line entries
  // ==========================================================================

  for (genvar i = 0; i < `FB_ENTRIES; i++) begin : g_entry
    fetch_line_entry #(
      .ENTRY_IDX (i)
    ) u_fetch_line_entry (
      .clk      (clk),
      .rst_n    (rst_n),
      .fill_i   (fill),
      .tag_i    (pc_i[31:4]),
      .lookup_o (lookups[i])
    );
  end

  fetch_inst_select u_fetch_inst_select (
    .pc_i         (pc_i),
    .lookups_i    (lookups),
    .bypass_i     (bypass),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o)
  );

endmodule

`default_nettype wire

//--- fetch_buffer_assert.sv
`default_nettype none

module fetch_buffer_assert (
  input wire        clk,
  input wire        rst_n,
  input wire        ar_valid_i,
  input wire        ar_ready_i,
  input wire [31:0] ar_addr_i,
  input wire        r_valid_i,
  input wire        r_ready_i,
  input wire        fill_we_i
);

  int unsigned fail_count = 0;

  // ==========================================================================
  // read channel protocol
  // ==========================================================================

  // address must hold until the icache takes it
  ar_hold: assert property (@(posedge clk) disable iff (rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else begin
      fail_count++;
      $error("ar_valid_o or ar_addr_o changed before ar_ready_i");
    end

  // only one refill phase at a time
  one_phase: assert property (@(posedge clk) disable iff (rst_n)
    !(ar_valid_i && r_ready_i))
    else begin
      fail_count++;
      $error("ar_valid_o and r_ready_o high together");
    end

  fill_on_xfer: assert property (@(posedge clk) disable iff (rst_n)
    fill_we_i |-> r_valid_i && r_ready_i)
    else begin
      fail_count++;
      $error("entry fill outside a data transfer cycle");
    end

endmodule

bind fetch_refill_ctrl fetch_buffer_assert u_fetch_buffer_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .ar_valid_i (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .ar_addr_i  (ar_addr_o),
  .r_valid_i  (r_valid_i),
  .r_ready_i  (r_ready_o),
  .fill_we_i  (fill_o.we)
);

`default_nettype wire

//--- tb_fetch_buffer.sv
`default_nettype none

`include "fetch_macros.svh"

module tb_fetch_buffer;

  // one line of the stimulus file
  typedef struct packed {
    logic [31:0] pc;
    logic        flush;
    logic        req;
    logic [3:0]  ar_dly;
    logic [3:0]  r_dly;
    logic [1:0]  resp;
    logic [31:0] inst;
  } step_t;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic [31:0]              pc_i;
  logic                     jmp_flush_i;
  logic                     ar_ready_i;
  logic                     r_valid_i;
  logic [`FB_LINE_BITS-1:0] r_data_i;
  logic [1:0]               r_resp_i;
  wire                      inst_valid_o;
  wire  [31:0]              inst_o;
  wire                      ar_valid_o;
  wire  [31:0]              ar_addr_o;
  wire                      r_ready_o;

  step_t       steps[$];
  int          num_steps = 0;
  int          step_no = 0;
  logic [31:0] rng_state = 32'h9cad;

  always #4 clk = ~clk;

  fetch_buffer_top u_fetch_buffer_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .pc_i         (pc_i),
    .jmp_flush_i  (jmp_flush_i),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o),
    .ar_valid_o   (ar_valid_o),
    .ar_addr_o    (ar_addr_o),
    .ar_ready_i   (ar_ready_i),
    .r_valid_i    (r_valid_i),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i),
    .r_ready_o    (r_ready_o)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  // icache model line where the word at byte address a holds a ^ 5a5a0000
  function automatic logic [`FB_LINE_BITS-1:0] make_line(input logic [31:0] pc);
    logic [31:0] base;
    base = {pc[31:4], 4'h0};
    return {base + 32'd12, base + 32'd8, base + 32'd4, base} ^ {4{32'h5a5a0000}};
  endfunction

  // delay field f means 0 to 3 random cycles
  task automatic pick_delay(input logic [3:0] field, output int cycles);
    if (field == 4'hf) begin
      rng_state = xorshift(rng_state);
      cycles    = {30'd0, rng_state[1:0]};
    end else begin
      cycles = {28'd0, field};
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] step %0d %s: expected %h, actual %h", step_no, what, expected, actual);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // entered and left on a falling edge
  task automatic run_step(input step_t s);
    int ar_wait;
    int r_wait;
    logic keep;
    check_value("no request pending", 32'd0, 32'(ar_valid_o));
    check_value("no data wait pending", 32'd0, 32'(r_ready_o));
    r_valid_i   = 1'b0;
    ar_ready_i  = 1'b0;
    jmp_flush_i = 1'b0;
    pc_i        = s.pc;
    #1;
    if (!s.req) begin
      check_value("hit valid", 32'd1, 32'(inst_valid_o));
      check_value("hit inst", s.inst, inst_o);
    end else begin
      check_value("miss valid", 32'd0, 32'(inst_valid_o));
      pick_delay(s.ar_dly, ar_wait);
      pick_delay(s.r_dly, r_wait);
      @(negedge clk);
      // request held with a stable line address under back-pressure
      for (int k = 0; k <= ar_wait; k++) begin
        if (k > 0) begin
          @(negedge clk);
        end
        check_value("ar_valid", 32'd1, 32'(ar_valid_o));
        check_value("ar_addr", {s.pc[31:4], 4'h0}, ar_addr_o);
      end
      ar_ready_i = 1'b1;
      @(negedge clk);
      ar_ready_i  = 1'b0;
      jmp_flush_i = s.flush;
      check_value("ar_valid after accept", 32'd0, 32'(ar_valid_o));
      for (int k = 0; k <= r_wait; k++) begin
        if (k > 0) begin
          @(negedge clk);
          jmp_flush_i = 1'b0;
        end
        check_value("r_ready", 32'd1, 32'(r_ready_o));
        check_value("valid while waiting", 32'd0, 32'(inst_valid_o));
      end
      r_valid_i = 1'b1;
      r_data_i  = make_line(s.pc);
      r_resp_i  = s.resp;
      keep = ((s.resp == fetch_pkg::RESP_OKAY) || (s.resp == fetch_pkg::RESP_EXOKAY)) &&
             !s.flush;
      #1;
      check_value("data valid", 32'(keep), 32'(inst_valid_o));
      check_value("data inst", s.inst, inst_o);
    end
    @(negedge clk);
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial begin
    int          fd;
    int          n;
    string       text;
    logic [31:0] f [7];
    step_t       s;
    rst_n       = 1'b1;
    pc_i        = 32'h0;
    jmp_flush_i = 1'b0;
    ar_ready_i  = 1'b0;
    r_valid_i   = 1'b0;
    r_data_i    = '0;
    r_resp_i    = 2'd0;
    fd = $fopen("fetch_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open fetch_testdata.txt");
      $display("STATUS: FAIL");
      $fatal(1, "no stimulus");
    end
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      // 8'h23 is the comment character
      if (text.len() > 1 && text.getc(0) != 8'h23) begin
        n = $sscanf(text, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
        if (n == 7) begin
          s.pc     = f[0];
          s.flush  = f[1][0];
          s.req    = f[2][0];
          s.ar_dly = f[3][3:0];
          s.r_dly  = f[4][3:0];
          s.resp   = f[5][1:0];
          s.inst   = f[6];
          steps.push_back(s);
        end
      end
    end
    $fclose(fd);
    num_steps = steps.size();
    if (num_steps == 0) begin
      $display("fetch_testdata.txt holds no stimulus lines");
      $display("STATUS: FAIL");
      $fatal(1, "empty stimulus");
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < num_steps; i++) begin
      step_no = i + 1;
      run_step(steps[i]);
    end
    check_value("no request after last step", 32'd0, 32'(ar_valid_o));
    if (u_fetch_buffer_top.u_fetch_refill_ctrl.u_fetch_buffer_assert.fail_count != 0) begin
      $display("read channel protocol assertions failed");
      $display("STATUS: FAIL");
      $fatal(1, "assertion failures");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

  // watchdog allows 40 cycles per stimulus line
  initial begin
    wait (num_steps > 0);
    repeat (num_steps * 40 + 10) @(posedge clk);
    $display("the run hung, watchdog expired after %0d steps", num_steps);
    $display("STATUS: FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire

//--- fetch_testdata.txt
# pc flush req ar_dly r_dly resp inst (hex), req 1 means a refill request is expected
# delay f is random 0..3 cycles, resp 0 okay 1 exokay 2 slverr 3 decerr, inst 0 if dropped
00001000 0 1 0 0 0 5a5a1000
00001004 0 0 0 0 0 5a5a1004
00001008 0 0 0 0 0 5a5a1008
0000100c 0 0 0 0 0 5a5a100c
00002008 0 1 3 2 0 5a5a2008
00003004 0 1 f f 1 5a5a3004
00004000 1 1 1 2 0 00000000
00005010 0 1 0 1 0 5a5a5010
00006004 0 1 0 1 2 00000000
00006004 0 1 1 0 0 5a5a6004
00008000 0 1 f f 0 5a5a8000
00009004 0 1 2 0 0 5a5a9004
0000a008 0 1 0 3 0 5a5aa008
0000b00c 0 1 f 1 0 5a5ab00c
0000c000 0 1 1 f 0 5a5ac000
00009000 0 0 0 0 0 5a5a9000
0000a004 0 0 0 0 0 5a5aa004
0000b008 0 0 0 0 0 5a5ab008
0000c00c 0 0 0 0 0 5a5ac00c
00008004 0 1 0 0 0 5a5a8004
00008008 0 0 0 0 0 5a5a8008

//--- fetch_buffer_top.f
+incdir+.
fetch_pkg.sv
fetch_line_entry.sv
fetch_refill_ctrl.sv
fetch_inst_select.sv
fetch_buffer_top.sv
fetch_buffer_assert.sv
tb_fetch_buffer.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_fetch_buffer -f fetch_buffer_top.f

out=$(./obj_dir/Vtb_fetch_buffer) || true
echo "$out"

if echo "$out" | grep -q "^STATUS: PASS$"; then
  exit 0
fi
exit 1
